/* fetch.f */
+incdir+.
fetch_core_pkg.sv
fetch_bus_pkg.sv
icache_port_if.sv
icache.sv
ifu.sv
fetch_top.sv
fetch_asserts.sv
fetch_tb.sv

/* run.sh */
#!/bin/bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f fetch.f --top-module fetch_tb

out=$(./obj_dir/Vfetch_tb)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
	exit 0
fi
exit 1

/* fetch_tb.sv */
`include "fetch_settings.svh"

module fetch_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import fetch_core_pkg::*;
	import fetch_bus_pkg::*;

	localparam inst_t DATA_KEY = 32'h5a5a_0000;
	localparam int    WAIT_LIMIT = 200;
	localparam int    N_TESTS = 9;

	typedef struct {
		addr_t exp_pc;
		addr_t next;
		logic  redir;
		addr_t redir_addr;
		int    stall;
		logic  exp_req;
	} test_row_t;

	logic       clock = 1'b0;
	logic       reset = 1'b1;
	addr_t      araddr;
	logic       arvalid;
	logic       arready = 1'b0;
	burst_t     arburst;
	burst_len_t arlen;
	inst_t      rdata = '0;
	logic       rvalid = 1'b0;
	logic       rlast = 1'b0;
	inst_t      inst;
	addr_t      inst_pc;
	logic       inst_valid;
	logic       inst_ready = 1'b0;
	logic       redirect = 1'b0;
	addr_t      redirect_addr = '0;
	addr_t      next_pc = '0;

	test_row_t  rows [N_TESTS];
	int         req_count = 0;
	int         accept_count = 0;
	int         errors = 0;
	int         delay = 0;
	logic       waiting = 1'b0;
	int         beats_left = 0;
	addr_t      beat_addr;
	addr_t      last_addr;
	burst_t     last_burst;
	burst_len_t last_len;

	fetch_top UUT (.*);

	always #50 clock = ~clock;

	// memory model, one request at a time.
	always @(posedge clock) begin
		arready <= 1'b0;
		rvalid  <= 1'b0;
		rlast   <= 1'b0;
		if (reset) begin
			waiting    = 1'b0;
			beats_left = 0;
		end else if (beats_left > 0) begin
			rvalid     <= 1'b1;
			rdata      <= beat_addr ^ DATA_KEY;
			rlast      <= (beats_left == 1);
			beat_addr  = beat_addr + 32'd4;
			beats_left = beats_left - 1;
		end else if (arvalid && arready) begin
			req_count  = req_count + 1;
			last_addr  = araddr;
			last_burst = arburst;
			last_len   = arlen;
			beat_addr  = araddr;
			beats_left = int'(arlen) + 1;
		end else if (arvalid) begin
			if (!waiting) begin
				waiting = 1'b1;
				delay   = $urandom % 4;
			end
			if (delay == 0) begin
				arready <= 1'b1;
				waiting = 1'b0;
			end else begin
				delay = delay - 1;
			end
		end
	end

	always @(posedge clock) begin
		if (!reset && inst_valid && inst_ready && !redirect)
			accept_count = accept_count + 1;
	end

	function automatic logic in_window(addr_t a);
		return (a >= `FETCH_SDRAM_BASE) && (a < `FETCH_SDRAM_LIMIT);
	endfunction

	task automatic check_inst(string what, inst_t got, inst_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(string what, addr_t got, addr_t exp);
		if (got !== exp) begin
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_burst(burst_t got_b, burst_len_t got_l, burst_t exp_b, burst_len_t exp_l);
		if (got_b !== exp_b || got_l !== exp_l) begin
			$display("error at %0t: burst %0d len %0d, expected %0d len %0d",
				$time, got_b, got_l, exp_b, exp_l);
			errors++;
		end
	endtask

	task automatic check_count(string what, int got, int exp);
		if (got != exp) begin
			$display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic wait_delivery(output logic timed_out);
		int n;
		n = 0;
		timed_out = 1'b0;
		@(posedge clock);
		while (!inst_valid && n < WAIT_LIMIT) begin
			@(posedge clock);
			n++;
		end
		timed_out = !inst_valid;
	endtask

	initial begin
		int    failed_tests;
		int    req_before;
		int    err_before;
		int    expected_accepts;
		int    assert_fails;
		logic  timed_out;
		addr_t held_pc;
		inst_t held_inst;

		rows[0] = '{32'h3000_0000, 32'ha000_0010, 1'b0, 32'h0, 0, 1'b1};
		rows[1] = '{32'ha000_0010, 32'ha000_0014, 1'b0, 32'h0, 0, 1'b1};
		rows[2] = '{32'ha000_0014, 32'ha000_001c, 1'b0, 32'h0, 0, 1'b0};
		rows[3] = '{32'ha000_001c, 32'ha000_0000, 1'b0, 32'h0, 4, 1'b0};
		rows[4] = '{32'ha000_0000, 32'h3000_0100, 1'b1, 32'h3000_0200, 1, 1'b0};
		rows[5] = '{32'h3000_0200, 32'h3000_0204, 1'b0, 32'h0, 2, 1'b1};
		rows[6] = '{32'h3000_0204, 32'ha000_0048, 1'b0, 32'h0, 0, 1'b1};
		rows[7] = '{32'ha000_0048, 32'ha000_004c, 1'b0, 32'h0, 0, 1'b1};
		rows[8] = '{32'ha000_004c, 32'h3000_0000, 1'b0, 32'h0, 0, 1'b0};
		failed_tests = 0;
		expected_accepts = 0;
		timed_out = 1'b0;
		void'($urandom(32'h5603));
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < N_TESTS; i++) begin
			req_before = req_count;
			err_before = errors;
			wait_delivery(timed_out);
			if (timed_out) begin
				$display("timeout: no instruction delivered for test %0d", i);
				failed_tests++;
				break;
			end
			check_addr("inst_pc", inst_pc, rows[i].exp_pc);
			check_inst("inst", inst, rows[i].exp_pc ^ DATA_KEY);
			check_count("requests", req_count - req_before, int'(rows[i].exp_req));
			if (rows[i].exp_req) begin
				if (in_window(rows[i].exp_pc)) begin
					check_addr("araddr", last_addr, rows[i].exp_pc & ~32'h1f);
					check_burst(last_burst, last_len, BURST_INCR, 4'd7);
				end else begin
					check_addr("araddr", last_addr, rows[i].exp_pc);
					check_burst(last_burst, last_len, BURST_FIXED, 4'd0);
				end
			end
			held_pc = inst_pc;
			held_inst = inst;
			req_before = req_count;
			for (int s = 0; s < rows[i].stall; s++) begin
				@(posedge clock);
				check_addr("held inst_pc", inst_pc, held_pc);
				check_inst("held inst", inst, held_inst);
			end
			check_count("requests while held", req_count - req_before, 0);
			if (rows[i].redir) begin
				redirect      <= 1'b1;
				redirect_addr <= rows[i].redir_addr;
				@(posedge clock);
				redirect <= 1'b0;
			end else begin
				inst_ready <= 1'b1;
				next_pc    <= rows[i].next;
				expected_accepts++;
				@(posedge clock);
				inst_ready <= 1'b0;
			end
			if (errors != err_before)
				failed_tests++;
			$display("test %0d pc %h: %s", i, rows[i].exp_pc,
				(errors == err_before) ? "ok" : "failed");
		end
		@(posedge clock);
		check_count("accepted instructions", accept_count, expected_accepts);
		assert_fails = UUT.fetch_unit.bound_checks.fail_count;
		$display("tests %0d failed %0d errors %0d assertion failures %0d",
			N_TESTS, failed_tests, errors, assert_fails);
		if (errors == 0 && !timed_out && assert_fails == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* fetch_asserts.sv */
`include "fetch_settings.svh"

module fetch_asserts (
	input logic                      clock,
	input logic                      reset,
	input fetch_core_pkg::addr_t     araddr,
	input logic                      arvalid,
	input logic                      arready,
	input fetch_bus_pkg::burst_len_t arlen,
	input fetch_core_pkg::inst_t     inst,
	input logic                      inst_valid,
	input logic                      inst_ready,
	input logic                      redirect
);
	timeunit 1ns;
	timeprecision 1ps;

	import fetch_bus_pkg::*;

	int   fail_count = 0;
	logic in_win;

	assign in_win = (araddr >= `FETCH_SDRAM_BASE) && (araddr < `FETCH_SDRAM_LIMIT);

	ar_stable: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			$error("araddr or arvalid changed before arready");
			fail_count++;
		end

	inst_stable: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect |=> inst_valid && $stable(inst))
		else begin
			$error("inst changed while held");
			fail_count++;
		end

	len_window: assert property (@(posedge clock) disable iff (reset)
		arvalid |-> ((arlen == burst_len_t'(`FETCH_LINE_WORDS - 1)) == in_win))
		else begin
			$error("arlen does not match the window");
			fail_count++;
		end

endmodule

bind ifu fetch_asserts bound_checks (
	.clock      (clock),
	.reset      (reset),
	.araddr     (araddr),
	.arvalid    (arvalid),
	.arready    (arready),
	.arlen      (arlen),
	.inst       (inst),
	.inst_valid (inst_valid),
	.inst_ready (inst_ready),
	.redirect   (redirect)
);

/* fetch_top.sv */
module fetch_top (
	input  logic                      clock,
	input  logic                      reset,
	output fetch_core_pkg::addr_t     araddr,
	output logic                      arvalid,
	input  logic                      arready,
	output fetch_bus_pkg::burst_t     arburst,
	output fetch_bus_pkg::burst_len_t arlen,
	input  fetch_core_pkg::inst_t     rdata,
	input  logic                      rvalid,
	input  logic                      rlast,
	output fetch_core_pkg::inst_t     inst,
	output fetch_core_pkg::addr_t     inst_pc,
	output logic                      inst_valid,
	input  logic                      inst_ready,
	input  logic                      redirect,
	input  fetch_core_pkg::addr_t     redirect_addr,
	input  fetch_core_pkg::addr_t     next_pc
);

	icache_port_if cache_port ();

	ifu fetch_unit (
		.clock         (clock),
		.reset         (reset),
		.araddr        (araddr),
		.arvalid       (arvalid),
		.arready       (arready),
		.arburst       (arburst),
		.arlen         (arlen),
		.rdata         (rdata),
		.rvalid        (rvalid),
		.rlast         (rlast),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.next_pc       (next_pc),
		.inst          (inst),
		.inst_pc       (inst_pc),
		.inst_valid    (inst_valid),
		.inst_ready    (inst_ready),
		.cache         (cache_port.fetch)
	);

	icache instr_cache (
		.clock (clock),
		.reset (reset),
		.port  (cache_port.cache)
	);

endmodule

/* ifu.sv */
`include "fetch_settings.svh"

module ifu (
	input  logic                      clock,
	input  logic                      reset,
	output fetch_core_pkg::addr_t     araddr,
	output logic                      arvalid,
	input  logic                      arready,
	output fetch_bus_pkg::burst_t     arburst,
	output fetch_bus_pkg::burst_len_t arlen,
	input  fetch_core_pkg::inst_t     rdata,
	input  logic                      rvalid,
	input  logic                      rlast,
	input  logic                      redirect,
	input  fetch_core_pkg::addr_t     redirect_addr,
	input  fetch_core_pkg::addr_t     next_pc,
	output fetch_core_pkg::inst_t     inst,
	output fetch_core_pkg::addr_t     inst_pc,
	output logic                      inst_valid,
	input  logic                      inst_ready,
	icache_port_if.fetch              cache
);
	import fetch_core_pkg::*;
	import fetch_bus_pkg::*;

	localparam addr_t LINE_MASK = addr_t'(`FETCH_LINE_WORDS * 4 - 1);

	fetch_state_t state;
	addr_t        pc;
	addr_t        fill_addr;
	logic         restart; // pc was replaced during a read.

	addr_t line_addr;
	logic  accept;
	logic  beat_match;
	logic  fill_beat;
	logic  read_end;
	logic  deliver;
	inst_t deliver_data;
	logic  start_fetch;
	addr_t start_addr;

	function automatic logic in_window(addr_t addr);
		return (addr >= `FETCH_SDRAM_BASE) && (addr < `FETCH_SDRAM_LIMIT);
	endfunction

	assign line_addr  = pc & ~LINE_MASK;
	assign accept     = inst_valid && inst_ready && !redirect; // redirect wins.
	assign beat_match = (word_idx_t'(fill_addr >> 2) == word_idx_t'(pc >> 2));
	assign fill_beat  = (state == ST_BURST) && rvalid;
	assign read_end   = rvalid && ((state == ST_SINGLE) || ((state == ST_BURST) && rlast));

	assign arburst = (state == ST_BURST) ? BURST_INCR : BURST_FIXED;
	assign arlen   = (state == ST_BURST) ? burst_len_t'(`FETCH_LINE_WORDS - 1) : '0;

	assign cache.lookup_addr = pc;
	assign cache.fill_addr   = fill_addr;
	assign cache.fill_data   = rdata;
	assign cache.fill_valid  = fill_beat;

	assign inst_pc = pc;

	// result for decode, dropped once pc has moved on.
	always_comb begin
		deliver      = 1'b0;
		deliver_data = rdata;
		if (!redirect && !restart) begin
			case (state)
				ST_LOOKUP: begin
					deliver      = cache.hit;
					deliver_data = cache.rdata;
				end
				ST_SINGLE: deliver = rvalid;
				ST_BURST:  deliver = rvalid && beat_match;
				default:   deliver = 1'b0;
			endcase
		end
	end

	// only from states with no bus read open.
	always_comb begin
		start_fetch = 1'b0;
		start_addr  = pc;
		case (state)
			ST_IDLE: start_fetch = 1'b1;
			ST_LOOKUP, ST_HOLD: begin
				if (redirect) begin
					start_fetch = 1'b1;
					start_addr  = redirect_addr;
				end else if (accept) begin
					start_fetch = 1'b1;
					start_addr  = next_pc;
				end
			end
			default: start_fetch = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (deliver)
			inst <= deliver_data;
	end

	always_ff @(posedge clock) begin
		if ((state == ST_LOOKUP) && !cache.hit)
			fill_addr <= line_addr;
		else if (fill_beat)
			fill_addr <= fill_addr + 32'd4;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= ST_SINGLE;
			pc         <= `FETCH_RESET_PC;
			araddr     <= `FETCH_RESET_PC;
			arvalid    <= 1'b1;
			inst_valid <= 1'b0;
			restart    <= 1'b0;
		end else begin
			if (arvalid && arready)
				arvalid <= 1'b0;
			if (start_fetch) begin
				pc         <= start_addr;
				inst_valid <= 1'b0;
				if (in_window(start_addr)) begin
					state <= ST_LOOKUP;
				end else begin
					state   <= ST_SINGLE;
					araddr  <= start_addr;
					arvalid <= 1'b1;
				end
			end else begin
				case (state)
					ST_LOOKUP: begin
						if (deliver) begin
							inst_valid <= 1'b1;
							state      <= ST_HOLD;
						end else begin
							araddr  <= line_addr; // miss, refill whole line.
							arvalid <= 1'b1;
							state   <= ST_BURST;
						end
					end
					ST_SINGLE, ST_BURST: begin
						if (redirect)
							pc <= redirect_addr;
						else if (accept)
							pc <= next_pc;
						if (deliver)
							inst_valid <= 1'b1;
						else if (redirect || accept)
							inst_valid <= 1'b0;
						if (read_end) begin
							restart <= 1'b0;
							state   <= (restart || redirect || accept) ? ST_IDLE : ST_HOLD;
						end else begin
							restart <= restart || redirect || accept;
						end
					end
					default: state <= state; // hold waits on decode.
				endcase
			end
		end
	end

endmodule

/* icache.sv */
`include "fetch_settings.svh"

module icache (
	input logic          clock,
	input logic          reset,
	icache_port_if.cache port
);
	import fetch_core_pkg::*;
	import fetch_bus_pkg::*;

	logic [`FETCH_LINES-1:0] line_valid;
	line_tag_t               tag_mem [`FETCH_LINES];
	inst_t                   data_mem [`FETCH_LINES][`FETCH_LINE_WORDS];

	line_idx_t rd_idx;
	line_tag_t rd_tag;
	word_idx_t rd_word;
	line_idx_t wr_idx;
	line_tag_t wr_tag;
	word_idx_t wr_word;
	logic      wr_first;
	logic      wr_last;

	assign rd_word = port.lookup_addr[LINE_OFFSET_BITS-1:2];
	assign rd_idx  = port.lookup_addr[LINE_OFFSET_BITS +: LINE_INDEX_BITS];
	assign rd_tag  = port.lookup_addr[31 -: LINE_TAG_BITS];

	assign wr_word = port.fill_addr[LINE_OFFSET_BITS-1:2];
	assign wr_idx  = port.fill_addr[LINE_OFFSET_BITS +: LINE_INDEX_BITS];
	assign wr_tag  = port.fill_addr[31 -: LINE_TAG_BITS];

	assign wr_first = (wr_word == '0);
	assign wr_last  = (wr_word == word_idx_t'(`FETCH_LINE_WORDS - 1));

	assign port.hit   = line_valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign port.rdata = data_mem[rd_idx][rd_word];

	// a line is invalid while it is being refilled.
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (port.fill_valid) begin
			if (wr_last)
				line_valid[wr_idx] <= 1'b1;
			else if (wr_first)
				line_valid[wr_idx] <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (port.fill_valid) begin
			data_mem[wr_idx][wr_word] <= port.fill_data;
			if (wr_last)
				tag_mem[wr_idx] <= wr_tag; // tag lands with the last word.
		end
	end

endmodule

/* icache_port_if.sv */
interface icache_port_if;
	import fetch_core_pkg::*;

	addr_t lookup_addr;
	logic  hit;        // combinational from lookup_addr.
	inst_t rdata;

	addr_t fill_addr;
	inst_t fill_data;
	logic  fill_valid; // one word per cycle.

	modport fetch (
		output lookup_addr, fill_addr, fill_data, fill_valid,
		input  hit, rdata
	);

	modport cache (
		input  lookup_addr, fill_addr, fill_data, fill_valid,
		output hit, rdata
	);

endinterface

/* fetch_bus_pkg.sv */
`include "fetch_settings.svh"

package fetch_bus_pkg;

	localparam int LINE_OFFSET_BITS = $clog2(`FETCH_LINE_WORDS) + 2;
	localparam int LINE_INDEX_BITS  = $clog2(`FETCH_LINES);
	localparam int LINE_TAG_BITS    = 32 - LINE_INDEX_BITS - LINE_OFFSET_BITS;

	typedef logic [1:0] burst_t;

	localparam burst_t BURST_FIXED = 2'd0;
	localparam burst_t BURST_INCR  = 2'd1;

	typedef logic [3:0] burst_len_t; // beats minus one.

	typedef logic [LINE_INDEX_BITS-1:0] line_idx_t;
	typedef logic [LINE_TAG_BITS-1:0]   line_tag_t;

endpackage

/* fetch_core_pkg.sv */
`include "fetch_settings.svh"

package fetch_core_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;

	typedef logic [$clog2(`FETCH_LINE_WORDS)-1:0] word_idx_t; // word within a line.

	typedef enum logic [2:0] {
		ST_IDLE,   // pc holds the next target.
		ST_LOOKUP, // cache lookup of pc.
		ST_SINGLE, // one-word bus read.
		ST_BURST,  // line refill.
		ST_HOLD    // waiting on decode.
	} fetch_state_t;

endpackage

/* fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// boot address of the core.
`define FETCH_RESET_PC 32'h3000_0000

// cached SDRAM window, limit is exclusive.
`define FETCH_SDRAM_BASE  32'ha000_0000
`define FETCH_SDRAM_LIMIT 32'ha200_0000

// 32-byte lines, one burst each.
`define FETCH_LINE_WORDS 8

// any power of two.
`define FETCH_LINES 16

`endif
